/* ssb_demod.f */
+incdir+logic
logic/ssb_demod_pkg.sv
logic/ssb_stream_if.sv
logic/cp_remover.sv
logic/fft8_engine.sv
logic/ssb_tagger.sv
logic/ssb_demod_top.sv
tests/ssb_demod_assertions.sv
tests/ssb_demod_tb.sv

/* Bender.yml */
package:
  name: ssb_demod

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/ssb_demod_pkg.sv
      - logic/ssb_stream_if.sv
      - logic/cp_remover.sv
      - logic/fft8_engine.sv
      - logic/ssb_tagger.sv
      - logic/ssb_demod_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/ssb_demod_assertions.sv
      - tests/ssb_demod_tb.sv

/* tests/ssb_demod_tb.sv */
`include "ssb_demod_macros.svh"

`default_nettype none

module ssb_demod_tb;
    import ssb_demod_pkg::*;

    localparam int  MAX_CYCLES = 4000;  // about twice the five tests together
    localparam int  N          = `SSB_FFT_LEN;
    localparam int  CR_FREE    = 0;     // credit back one cycle after each item
    localparam int  CR_SLOW    = 1;     // one credit every 5 to 12 cycles
    localparam int  CR_HOLD    = 2;
    localparam real PI         = 3.14159265358979;

    typedef struct packed {
        logic                     kind;
        logic                     first;
        logic [`SSB_SAMPLE_W-1:0] re;
        logic [`SSB_SAMPLE_W-1:0] im;
    } item_t;

    logic                            clk;
    logic                            reset_n;
    logic signed [`SSB_SAMPLE_W-1:0] in_re;
    logic signed [`SSB_SAMPLE_W-1:0] in_im;
    logic                            in_valid;
    logic                            ssb_start;
    logic                            credit;
    logic signed [`SSB_SAMPLE_W-1:0] out_re;
    logic signed [`SSB_SAMPLE_W-1:0] out_im;
    logic                            out_valid;
    symbol_kind_e                    out_kind;
    logic                            out_first;
    logic                            overflow;

    logic [31:0] lfsr;
    item_t       exp_q [$];
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          item_idx = 0;
    int          keep_left;      // expected items still to queue
    bit          gaps;
    int          credit_mode;
    int          owed;
    int          credit_wait;
    bit          ovf_allowed;
    bit          ovf_reported;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ssb_demod_top dut_i (
        .clk_i       (clk),
        .reset_ni    (reset_n),
        .in_re_i     (in_re),
        .in_im_i     (in_im),
        .in_valid_i  (in_valid),
        .ssb_start_i (ssb_start),
        .credit_i    (credit),
        .out_re_o    (out_re),
        .out_im_o    (out_im),
        .out_valid_o (out_valid),
        .out_kind_o  (out_kind),
        .out_first_o (out_first),
        .overflow_o  (overflow)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};  // one step per bit
        end
        return v;
    endfunction

    // 12 bit values leave headroom through the three stages
    function automatic sample_t rand_sample();
        sample_t     s;
        logic [11:0] v;
        v = rand_bits(12);
        s.re = `SSB_SAMPLE_W'(signed'(v));
        v = rand_bits(12);
        s.im = `SSB_SAMPLE_W'(signed'(v));
        return s;
    endfunction

    // radix-2 DIT where each butterfly halves and the twiddle product drops the Q8 fraction
    function automatic void ref_fft8(input sample_t x [N], output sample_t y [N]);
        sample_t v [N];
        int      half;
        int      k;
        int      a_re;
        int      a_im;
        int      b_re;
        int      b_im;
        int      w_re;
        int      w_im;
        int      prod_re;
        int      prod_im;
        for (int n = 0; n < N; n++) begin
            v[{n[0], n[1], n[2]}] = x[n];  // bit-reversed load
        end
        for (int s = 1; s <= 3; s++) begin
            half = 1 << (s - 1);
            for (int base = 0; base < N; base += 2 * half) begin
                for (int j = 0; j < half; j++) begin
                    k    = j * (N / (2 * half));
                    w_re = int'(256.0 * $cos(2.0 * PI * k / N));
                    w_im = int'(-256.0 * $sin(2.0 * PI * k / N));
                    a_re = v[base + j].re;
                    a_im = v[base + j].im;
                    b_re = v[base + j + half].re;
                    b_im = v[base + j + half].im;
                    prod_re = (w_re * b_re - w_im * b_im) >>> `SSB_TWIDDLE_FRAC;
                    prod_im = (w_re * b_im + w_im * b_re) >>> `SSB_TWIDDLE_FRAC;
                    v[base + j].re        = `SSB_SAMPLE_W'((a_re + prod_re) >>> 1);
                    v[base + j].im        = `SSB_SAMPLE_W'((a_im + prod_im) >>> 1);
                    v[base + j + half].re = `SSB_SAMPLE_W'((a_re - prod_re) >>> 1);
                    v[base + j + half].im = `SSB_SAMPLE_W'((a_im - prod_im) >>> 1);
                end
            end
        end
        y = v;
    endfunction

    function automatic void expect_item(input sample_t s, input symbol_kind_e kind,
                                        input logic first);
        item_t it;
        it.kind  = kind;
        it.first = first;
        it.re    = s.re;
        it.im    = s.im;
        if (keep_left > 0) begin
            exp_q.push_back(it);
            keep_left--;
        end
    endfunction

    function automatic int total_errors();
        return errors + dut_i.checks_i.assert_errs;
    endfunction

    task automatic drive(input logic valid, input logic start, input sample_t s);
        @(posedge clk);
        #1;
        in_valid  = valid;
        ssb_start = start;
        in_re     = s.re;
        in_im     = s.im;
    endtask

    task automatic send_valid(output sample_t s);
        if (gaps) begin
            while (rand_bits(2) == 0) drive(1'b0, 1'b0, rand_sample());
        end
        s = rand_sample();
        drive(1'b1, 1'b0, s);
    endtask

    task automatic send_block();
        sample_t x [N];
        sample_t y [N];
        sample_t junk;
        drive(1'b1, 1'b1, rand_sample());  // valid beside the start pulse is dropped
        for (int sym = 0; sym < `SSB_SYMBOLS; sym++) begin
            if (sym > 0) begin
                for (int c = 0; c < `SSB_CP_LEN; c++) send_valid(junk);
            end
            for (int n = 0; n < N; n++) send_valid(x[n]);
            ref_fft8(x, y);
            for (int n = 0; n < N; n++) begin
                expect_item(y[n], (sym == 1) ? KIND_SSS : KIND_PBCH, n == 0);
            end
        end
        drive(1'b0, 1'b0, '0);
    endtask

    task automatic send_stray(input int count);
        for (int i = 0; i < count; i++) drive(1'b1, 1'b0, rand_sample());
        drive(1'b0, 1'b0, '0);
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("output stalled, %0d expected items never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (30) @(posedge clk);  // room for stray extra items
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == errors_at_start) begin
            $display("test %-16s ok", name);
        end else begin
            tests_failed++;
            $display("test %-16s %0d errors", name, total_errors() - errors_at_start);
        end
        errors_at_start = total_errors();
        keep_left = 1000;
    endtask

    always @(posedge clk) begin
        item_t e;
        if (reset_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("extra output item, re %h im %h", out_re, out_im);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (out_re !== e.re) begin
                    $display("ERR out_re_o got %h exp %h at item %0d", out_re, e.re, item_idx);
                    errors++;
                end
                if (out_im !== e.im) begin
                    $display("ERR out_im_o got %h exp %h at item %0d", out_im, e.im, item_idx);
                    errors++;
                end
                if (out_kind !== e.kind) begin
                    $display("ERR out_kind_o got %h exp %h at item %0d", out_kind, e.kind,
                             item_idx);
                    errors++;
                end
                if (out_first !== e.first) begin
                    $display("ERR out_first_o got %h exp %h at item %0d", out_first, e.first,
                             item_idx);
                    errors++;
                end
            end
            item_idx++;
        end
        if (reset_n && overflow && !ovf_allowed && !ovf_reported) begin
            $display("overflow flag set although every bin fits");
            errors++;
            ovf_reported = 1'b1;
        end
    end

    // consumer side of the credit link
    always @(posedge clk) begin
        logic give;
        give = 1'b0;
        if (!reset_n) begin
            owed        = 0;
            credit_wait = 0;
        end else begin
            if (out_valid) owed++;
            case (credit_mode)
                CR_FREE: give = owed > 0;
                CR_SLOW: begin
                    if (credit_wait > 0) begin
                        credit_wait--;
                    end else if (owed > 0) begin
                        give        = 1'b1;
                        credit_wait = 4 + int'(rand_bits(3));
                    end
                end
                default: give = 1'b0;
            endcase
            if (give) owed--;
        end
        credit <= #1 give;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int waited;
        lfsr         = 32'h2ac0097d;
        reset_n      = 1'b0;
        in_re        = '0;
        in_im        = '0;
        in_valid     = 1'b0;
        ssb_start    = 1'b0;
        credit       = 1'b0;
        gaps         = 1'b0;
        credit_mode  = CR_FREE;
        keep_left    = 1000;
        ovf_allowed  = 1'b0;
        ovf_reported = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        send_block();
        wait_drain(200);
        end_test("one_block");

        gaps = 1'b1;
        send_block();
        wait_drain(300);
        gaps = 1'b0;
        end_test("valid_gaps");

        credit_mode = CR_SLOW;
        send_block();
        wait_drain(600);
        credit_mode = CR_FREE;
        end_test("credit_throttle");

        send_stray(10);  // framer idle so all are dropped
        send_block();
        send_stray(10);  // after the third symbol
        wait_drain(200);
        send_block();
        wait_drain(200);
        end_test("framing_gates");

        credit_mode = CR_HOLD;
        ovf_allowed = 1'b1;
        keep_left   = 3 * N;  // 8 out and 16 held while the rest is lost
        send_block();
        send_block();
        waited = 0;
        while (!overflow && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!overflow) begin
            $display("overflow flag never rose with credits withheld");
            errors++;
        end
        if (exp_q.size() != 2 * N) begin
            $display("%0d bins came out before credits ran out, %0d expected",
                     3 * N - exp_q.size(), N);
            errors++;
        end
        // framer register, FFT latency and 8 bins until block two has met the full FIFO
        repeat (1 + 4 + N) @(negedge clk);
        credit_mode = CR_FREE;
        wait_drain(200);
        apply_reset();
        if (overflow !== 1'b0) begin
            $display("ERR overflow_o got %h exp %h after reset", overflow, 1'b0);
            errors++;
        end
        ovf_allowed = 1'b0;
        end_test("overflow");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/ssb_demod_assertions.sv */
`include "ssb_demod_macros.svh"

`default_nettype none

module ssb_demod_assertions (
    input wire logic clk_i,
    input wire logic reset_ni,
    input wire logic credit_i,
    input wire logic out_valid_o,
    input wire logic out_first_o,
    input wire logic overflow_o
);
    int outstanding;      // items out minus credits back
    int assert_errs = 0;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(out_valid_o) - int'(credit_i);
        end
    end

    a_credit_limit: assert property (@(posedge clk_i) disable iff (!reset_ni)
        outstanding <= `SSB_OUT_CREDITS)
    else begin
        $error("more items outstanding than credits");
        assert_errs++;
    end

    // registered output, so low from the cycle after a reset edge
    a_valid_in_reset: assert property (@(posedge clk_i) !reset_ni |=> !out_valid_o)
    else begin
        $error("out_valid_o high after a reset cycle");
        assert_errs++;
    end

    a_overflow_sticky: assert property (@(posedge clk_i)
        $fell(overflow_o) |-> !$past(reset_ni))
    else begin
        $error("overflow_o cleared without reset");
        assert_errs++;
    end

    a_first_needs_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_first_o |-> out_valid_o)
    else begin
        $error("out_first_o without out_valid_o");
        assert_errs++;
    end

endmodule

bind ssb_demod_top ssb_demod_assertions checks_i (
    .clk_i       (clk_i),
    .reset_ni    (reset_ni),
    .credit_i    (credit_i),
    .out_valid_o (out_valid_o),
    .out_first_o (out_first_o),
    .overflow_o  (overflow_o)
);

`default_nettype wire

/* logic/ssb_demod_top.sv */
`include "ssb_demod_macros.svh"

`default_nettype none

module ssb_demod_top (
    input  wire logic                             clk_i,
    input  wire logic                             reset_ni,
    input  wire logic signed [`SSB_SAMPLE_W-1:0]  in_re_i,
    input  wire logic signed [`SSB_SAMPLE_W-1:0]  in_im_i,
    input  wire logic                             in_valid_i,
    input  wire logic                             ssb_start_i,
    input  wire logic                             credit_i,
    output logic signed [`SSB_SAMPLE_W-1:0]       out_re_o,
    output logic signed [`SSB_SAMPLE_W-1:0]       out_im_o,
    output logic                                  out_valid_o,
    output ssb_demod_pkg::symbol_kind_e           out_kind_o,
    output logic                                  out_first_o,
    output logic                                  overflow_o
);

    ssb_stream_if cp_if ();   // useful samples
    ssb_stream_if bin_if ();  // FFT bins

    cp_remover cp_remover_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_re_i     (in_re_i),
        .in_im_i     (in_im_i),
        .in_valid_i  (in_valid_i),
        .ssb_start_i (ssb_start_i),
        .out         (cp_if.source)
    );

    fft8_engine fft8_engine_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .in       (cp_if.sink),
        .out      (bin_if.source)
    );

    ssb_tagger ssb_tagger_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .credit_i    (credit_i),
        .in          (bin_if.sink),
        .out_re_o    (out_re_o),
        .out_im_o    (out_im_o),
        .out_valid_o (out_valid_o),
        .out_kind_o  (out_kind_o),
        .out_first_o (out_first_o),
        .overflow_o  (overflow_o)
    );

endmodule

`default_nettype wire

/* logic/ssb_tagger.sv */
`include "ssb_demod_macros.svh"

`default_nettype none

module ssb_tagger (
    input  wire logic                             clk_i,
    input  wire logic                             reset_ni,
    input  wire logic                             credit_i,
    ssb_stream_if.sink                            in,
    output logic signed [`SSB_SAMPLE_W-1:0]       out_re_o,
    output logic signed [`SSB_SAMPLE_W-1:0]       out_im_o,
    output logic                                  out_valid_o,
    output ssb_demod_pkg::symbol_kind_e           out_kind_o,
    output logic                                  out_first_o,
    output logic                                  overflow_o
);
    import ssb_demod_pkg::*;

    localparam int PTR_W = $clog2(`SSB_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`SSB_FIFO_DEPTH + 1);
    localparam int CRD_W = $clog2(`SSB_OUT_CREDITS + 1);
    localparam int SYM_W = $clog2(`SSB_SYMBOLS);

    sample_t          fifo_data  [`SSB_FIFO_DEPTH];
    symbol_kind_e     fifo_kind  [`SSB_FIFO_DEPTH];
    logic             fifo_first [`SSB_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic [CRD_W-1:0] credits;
    logic [SYM_W-1:0] sym_cnt;
    symbol_kind_e     kind;
    logic             full;
    logic             push;
    logic             pop;

    // only the middle symbol carries SSS
    assign kind = (sym_cnt == SYM_W'(1)) ? KIND_SSS : KIND_PBCH;
    assign full = fill == CNT_W'(`SSB_FIFO_DEPTH);
    assign push = in.valid && !full;
    assign pop  = (fill != '0) && (credits != '0);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sym_cnt <= '0;
        end else if (in.valid && in.last) begin
            if (sym_cnt == SYM_W'(`SSB_SYMBOLS - 1)) sym_cnt <= '0;
            else sym_cnt <= sym_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_data[wr_ptr]  <= in.data;
            fifo_kind[wr_ptr]  <= kind;
            fifo_first[wr_ptr] <= in.first;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            credits     <= CRD_W'(`SSB_OUT_CREDITS);
            overflow_o  <= 1'b0;
            out_valid_o <= 1'b0;
            out_first_o <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            fill    <= fill + CNT_W'(push) - CNT_W'(pop);
            credits <= credits + CRD_W'(credit_i) - CRD_W'(pop);  // spent at pop
            if (in.valid && full) overflow_o <= 1'b1;  // sticky, bin is lost
            out_valid_o <= pop;
            out_first_o <= pop && fifo_first[rd_ptr];
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            out_re_o   <= fifo_data[rd_ptr].re;
            out_im_o   <= fifo_data[rd_ptr].im;
            out_kind_o <= fifo_kind[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* logic/fft8_engine.sv */
`include "ssb_demod_macros.svh"

`default_nettype none

module fft8_engine (
    input  wire logic  clk_i,
    input  wire logic  reset_ni,
    ssb_stream_if.sink   in,
    ssb_stream_if.source out
);
    import ssb_demod_pkg::*;

    localparam int N      = `SSB_FFT_LEN;
    localparam int LOG_N  = $clog2(N);
    localparam int FRAC   = `SSB_TWIDDLE_FRAC;
    localparam int TW_W   = FRAC + 2;                      // holds -256..256
    localparam int PROD_W = `SSB_SAMPLE_W + TW_W + 1;
    localparam int TW_ONE = 2 ** FRAC;                     // 256
    localparam int TW_R2  = 181;                           // 256/sqrt(2) rounded

    sample_t           bank [2][N];   // ping-pong symbol buffers
    sample_t           stage_res [N];
    logic              wr_sel;        // buffer being filled
    logic [LOG_N-1:0]  wr_idx;
    logic [LOG_N-1:0]  wr_addr;
    fft_phase_e        phase;
    logic              cmp_sel;       // buffer being transformed
    logic              emitting;
    logic              rd_sel;
    logic [LOG_N-1:0]  rd_idx;

    function automatic logic [LOG_N-1:0] bitrev(input logic [LOG_N-1:0] idx);
        logic [LOG_N-1:0] r;
        for (int b = 0; b < LOG_N; b++) begin
            r[b] = idx[LOG_N-1-b];
        end
        return r;
    endfunction

    // one output of a radix-2 butterfly, a +/- w*b with both shifts
    function automatic sample_t bfly(input sample_t a, input sample_t b,
                                     input logic [LOG_N-2:0] k, input logic diff);
        logic signed [TW_W-1:0]   w_re;
        logic signed [TW_W-1:0]   w_im;
        logic signed [PROD_W-1:0] p_re;
        logic signed [PROD_W-1:0] p_im;
        logic signed [PROD_W-1:0] s_re;
        logic signed [PROD_W-1:0] s_im;
        sample_t                  r;
        case (k)  // e^(-j*2*pi*k/8)
            2'd0: begin
                w_re = TW_W'(TW_ONE);
                w_im = '0;
            end
            2'd1: begin
                w_re = TW_W'(TW_R2);
                w_im = -TW_W'(TW_R2);
            end
            2'd2: begin
                w_re = '0;
                w_im = -TW_W'(TW_ONE);
            end
            default: begin
                w_re = -TW_W'(TW_R2);
                w_im = -TW_W'(TW_R2);
            end
        endcase
        p_re = w_re * b.re - w_im * b.im;
        p_im = w_re * b.im + w_im * b.re;
        p_re = p_re >>> FRAC;  // back to sample scale
        p_im = p_im >>> FRAC;
        s_re = diff ? a.re - p_re : a.re + p_re;
        s_im = diff ? a.im - p_im : a.im + p_im;
        s_re = s_re >>> 1;     // per-stage scaling, no growth
        s_im = s_im >>> 1;
        r.re = s_re[`SSB_SAMPLE_W-1:0];
        r.im = s_im[`SSB_SAMPLE_W-1:0];
        return r;
    endfunction

    // in-place DIT stage on the buffer under compute
    always_comb begin
        int sh;
        int span;
        int k;
        case (phase)
            FFT_STAGE2: sh = 1;
            FFT_STAGE3: sh = 2;
            default:    sh = 0;
        endcase
        span = 1 << sh;
        stage_res = bank[cmp_sel];
        for (int i = 0; i < N; i++) begin
            if ((i & span) == 0) begin
                k = (i & (span - 1)) << (LOG_N - 1 - sh);
                stage_res[i] = bfly(bank[cmp_sel][i], bank[cmp_sel][i+span],
                                    (LOG_N-1)'(k), 1'b0);
                stage_res[i+span] = bfly(bank[cmp_sel][i], bank[cmp_sel][i+span],
                                         (LOG_N-1)'(k), 1'b1);
            end
        end
    end

    assign wr_addr = in.first ? '0 : wr_idx;

    always_ff @(posedge clk_i) begin
        if (in.valid) bank[wr_sel][bitrev(wr_addr)] <= in.data;
        if (phase != FFT_WAIT) bank[cmp_sel] <= stage_res;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_sel   <= 1'b0;
            wr_idx   <= '0;
            phase    <= FFT_WAIT;
            cmp_sel  <= 1'b0;
            emitting <= 1'b0;
            rd_sel   <= 1'b0;
            rd_idx   <= '0;
        end else begin
            if (in.valid) begin
                wr_idx <= wr_addr + 1'b1;
                if (in.last) wr_sel <= ~wr_sel;  // next symbol to the other buffer
            end

            if (emitting) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == LOG_N'(N - 1)) emitting <= 1'b0;
            end

            case (phase)
                FFT_WAIT: begin
                    if (in.valid && in.last) begin
                        cmp_sel <= wr_sel;
                        phase   <= FFT_STAGE1;
                    end
                end
                FFT_STAGE1: phase <= FFT_STAGE2;
                FFT_STAGE2: phase <= FFT_STAGE3;
                FFT_STAGE3: begin
                    phase    <= FFT_WAIT;
                    emitting <= 1'b1;  // bins follow in natural order
                    rd_sel   <= cmp_sel;
                    rd_idx   <= '0;
                end
            endcase
        end
    end

    assign out.valid = emitting;
    assign out.data  = bank[rd_sel][rd_idx];
    assign out.first = emitting && (rd_idx == '0);
    assign out.last  = emitting && (rd_idx == LOG_N'(N - 1));

endmodule

`default_nettype wire

/* logic/cp_remover.sv */
`include "ssb_demod_macros.svh"

`default_nettype none

module cp_remover (
    input  wire logic                             clk_i,
    input  wire logic                             reset_ni,
    input  wire logic signed [`SSB_SAMPLE_W-1:0]  in_re_i,
    input  wire logic signed [`SSB_SAMPLE_W-1:0]  in_im_i,
    input  wire logic                             in_valid_i,
    input  wire logic                             ssb_start_i,
    ssb_stream_if.source                          out
);
    import ssb_demod_pkg::*;

    localparam int SAMP_W = $clog2(`SSB_FFT_LEN);
    localparam int CP_W   = $clog2(`SSB_CP_LEN + 1);
    localparam int SYM_W  = $clog2(`SSB_SYMBOLS);

    framer_state_e     state;
    logic [CP_W-1:0]   cp_cnt;    // valid prefix samples seen
    logic [SAMP_W-1:0] samp_cnt;  // position inside the symbol
    logic [SYM_W-1:0]  sym_cnt;
    logic              take;
    logic              sym_end;

    assign take    = in_valid_i && (state == FR_COLLECT);
    assign sym_end = samp_cnt == SAMP_W'(`SSB_FFT_LEN - 1);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state    <= FR_IDLE;
            cp_cnt   <= '0;
            samp_cnt <= '0;
            sym_cnt  <= '0;
        end else begin
            case (state)
                FR_IDLE: begin
                    // prefix of symbol 0 is gone before the start pulse
                    if (ssb_start_i) state <= FR_COLLECT;
                end
                FR_SKIP_CP: begin
                    if (in_valid_i) begin  // gaps don't count
                        if (cp_cnt == CP_W'(`SSB_CP_LEN - 1)) begin
                            cp_cnt <= '0;
                            state  <= FR_COLLECT;
                        end else begin
                            cp_cnt <= cp_cnt + 1'b1;
                        end
                    end
                end
                FR_COLLECT: begin
                    if (in_valid_i) begin
                        if (sym_end) begin
                            samp_cnt <= '0;
                            if (sym_cnt == SYM_W'(`SSB_SYMBOLS - 1)) begin
                                sym_cnt <= '0;
                                state   <= FR_IDLE;  // block done
                            end else begin
                                sym_cnt <= sym_cnt + 1'b1;
                                state   <= FR_SKIP_CP;
                            end
                        end else begin
                            samp_cnt <= samp_cnt + 1'b1;
                        end
                    end
                end
                default: state <= FR_IDLE;
            endcase
        end
    end

    // one register stage towards the FFT
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out.valid <= 1'b0;
            out.first <= 1'b0;
            out.last  <= 1'b0;
        end else begin
            out.valid <= take;
            out.first <= take && (samp_cnt == '0);
            out.last  <= take && sym_end;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            out.data.re <= in_re_i;
            out.data.im <= in_im_i;
        end
    end

endmodule

`default_nettype wire

/* logic/ssb_stream_if.sv */
`default_nettype none

// complex sample stream between two stages
// no ready, the sink takes every valid beat
interface ssb_stream_if;
    import ssb_demod_pkg::*;

    sample_t data;
    logic    valid;
    logic    first;   // index 0 of a symbol
    logic    last;    // index FFT_LEN-1

    modport source (
        output data,
        output valid,
        output first,
        output last
    );

    modport sink (
        input data,
        input valid,
        input first,
        input last
    );

endinterface

`default_nettype wire

/* logic/ssb_demod_pkg.sv */
`include "ssb_demod_macros.svh"

`default_nettype none

package ssb_demod_pkg;

    // one complex sample, real part in the upper half
    typedef struct packed {
        logic signed [`SSB_SAMPLE_W-1:0] re;
        logic signed [`SSB_SAMPLE_W-1:0] im;
    } sample_t;

    typedef enum logic [1:0] {
        FR_IDLE,     // waiting for SS block start
        FR_SKIP_CP,
        FR_COLLECT
    } framer_state_e;

    typedef enum logic [1:0] {
        FFT_WAIT,
        FFT_STAGE1,  // span 1
        FFT_STAGE2,  // span 2
        FFT_STAGE3   // span 4
    } fft_phase_e;

    typedef enum logic {
        KIND_PBCH,
        KIND_SSS
    } symbol_kind_e;

endpackage

`default_nettype wire

/* logic/ssb_demod_macros.svh */
`ifndef SSB_DEMOD_MACROS_SVH
`define SSB_DEMOD_MACROS_SVH

`default_nettype none

// sample format
`define SSB_SAMPLE_W     16   // bits per signed component

// framing
`define SSB_FFT_LEN      8    // useful samples per OFDM symbol
`define SSB_CP_LEN       2    // prefix ahead of symbols 1 and 2
`define SSB_SYMBOLS      3    // PBCH, SSS, PBCH

// output link
`define SSB_OUT_CREDITS  8
`define SSB_FIFO_DEPTH   16

`define SSB_TWIDDLE_FRAC 8    // twiddles in Q8, so 1.0 is 256

`default_nettype wire

`endif
